// ==== norm_pkg.sv ====
package norm_pkg;

    // datapath widths
    localparam int MANT_W = 128;
    localparam int EXP_W  = 16;
    localparam int TAG_W  = 8;

    // bit index of the leading one, 0..127
    localparam int LZC_W = 7;

    // operand queue between ingress and normalizer
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

    // operand as it arrives from outside
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] mant;
    } norm_in_t;

    // normalized result, leading one at bit 127 unless zero
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] mant;
        logic              zero;
        logic              uflow;
    } norm_out_t;

    // four-phase handshake states
    // receiver:  IDLE -> (WAIT_ACK while full) -> WAIT_RELEASE -> IDLE
    // sender:    IDLE -> WAIT_ACK -> WAIT_RELEASE -> IDLE
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_WAIT_ACK,
        HS_WAIT_RELEASE
    } hs_state_t;

endpackage

// ==== lzc_64.sv ====
`timescale 1ns/1ps

module lzc_64 (
    input  logic [63:0] data_in,
    output logic [5:0]  lzc,
    output logic        valid
);

    // level 0 holds 32 two-bit cells, each further level halves the node count
    // and adds one index bit, the upper child's valid
    for (genvar lvl = 0; lvl < 6; lvl++) begin : g_level
        logic [(32 >> lvl)-1:0] vld;
        logic [lvl:0]           idx [32 >> lvl];

        if (lvl == 0) begin : g_leaf
            for (genvar n = 0; n < 32; n++) begin : g_cell
                assign vld[n] = data_in[2*n+1] | data_in[2*n];
                assign idx[n] = data_in[2*n+1];
            end
        end else begin : g_merge
            for (genvar n = 0; n < (32 >> lvl); n++) begin : g_node
                logic         hi_vld;
                logic [lvl-1:0] hi_idx;
                logic [lvl-1:0] lo_idx;

                assign hi_vld = g_level[lvl-1].vld[2*n+1];
                assign hi_idx = g_level[lvl-1].idx[2*n+1];
                assign lo_idx = g_level[lvl-1].idx[2*n];

                assign vld[n] = hi_vld | g_level[lvl-1].vld[2*n];
                // upper index is zero when the upper child is empty
                assign idx[n] = {hi_vld, hi_idx | ({lvl{~hi_vld}} & lo_idx)};
            end
        end
    end

    assign lzc   = g_level[5].idx[0];
    assign valid = g_level[5].vld[0];

endmodule

// ==== lzc_128.sv ====
`timescale 1ns/1ps

module lzc_128 (
    input  logic [127:0] data_in,
    output logic [6:0]   lzc,
    output logic         valid
);

    logic [5:0] lower_count;
    logic [5:0] upper_count;
    logic       lower_valid;
    logic       upper_valid;
    logic [5:0] lower_sel;

    lzc_64 i_lzc_lo (
        .data_in(data_in[63:0]),
        .lzc    (lower_count),
        .valid  (lower_valid)
    );

    lzc_64 i_lzc_hi (
        .data_in(data_in[127:64]),
        .lzc    (upper_count),
        .valid  (upper_valid)
    );

    // lower half only counts when the upper half is empty
    assign lower_sel = {6{~upper_valid}} & lower_count;

    assign valid      = upper_valid | lower_valid;
    assign lzc[5:0]   = upper_count | lower_sel;
    assign lzc[6]     = upper_valid;

endmodule

// ==== norm_ingress.sv ====
`timescale 1ns/1ps

module norm_ingress import norm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_req,
    input  norm_in_t in_data,
    output logic     in_ack,
    input  logic     full,
    output logic     push,
    output norm_in_t push_data
);

    hs_state_t state;
    hs_state_t state_next;

    // write once per request, never while the queue is full
    assign push      = in_req && !full && (state != HS_WAIT_RELEASE);
    assign push_data = in_data;
    assign in_ack    = (state == HS_WAIT_RELEASE);

    always_comb begin
        state_next = state;
        case (state)
            HS_IDLE: begin
                if (in_req) begin
                    state_next = full ? HS_WAIT_ACK : HS_WAIT_RELEASE;
                end
            end
            // request seen, held back by a full queue
            HS_WAIT_ACK: begin
                if (!in_req) begin
                    state_next = HS_IDLE;
                end else if (!full) begin
                    state_next = HS_WAIT_RELEASE;
                end
            end
            HS_WAIT_RELEASE: begin
                if (!in_req) begin
                    state_next = HS_IDLE;
                end
            end
            default: state_next = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== norm_fifo.sv ====
`timescale 1ns/1ps

module norm_fifo import norm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  norm_in_t push_data,
    input  logic     pop,
    output norm_in_t head,
    output logic     full,
    output logic     empty
);

    norm_in_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // fall-through read of the oldest entry
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== norm_shifter.sv ====
`timescale 1ns/1ps

module norm_shifter import norm_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  norm_in_t  head,
    input  logic      empty,
    output logic      pop,
    output logic      out_req,
    output norm_out_t out_data,
    input  logic      out_ack
);

    hs_state_t        state;
    hs_state_t        state_next;
    logic [LZC_W-1:0] lead_idx;
    logic             lead_vld;
    logic [LZC_W-1:0] shift;
    norm_out_t        result;

    lzc_128 i_lzc (
        .data_in(head.mant),
        .lzc    (lead_idx),
        .valid  (lead_vld)
    );

    // distance of the leading one from bit 127
    assign shift = LZC_W'(MANT_W - 1) - lead_idx;

    always_comb begin
        result.tag   = head.tag;
        result.zero  = 1'b0;
        result.uflow = 1'b0;
        result.mant  = head.mant << shift;
        result.exp   = head.exp - EXP_W'(shift);
        if (!lead_vld) begin
            result.mant = '0;
            result.exp  = '0;
            result.zero = 1'b1;
        end else if (head.exp <= EXP_W'(shift)) begin
            // exponent would reach zero or wrap, mantissa still normalized
            result.exp   = '0;
            result.uflow = 1'b1;
        end
    end

    // one pop per result, only between handshakes
    assign pop     = (state == HS_IDLE) && !empty;
    assign out_req = (state == HS_WAIT_ACK);

    always_comb begin
        state_next = state;
        case (state)
            HS_IDLE: begin
                if (!empty) begin
                    state_next = HS_WAIT_ACK;
                end
            end
            HS_WAIT_ACK: begin
                if (out_ack) begin
                    state_next = HS_WAIT_RELEASE;
                end
            end
            HS_WAIT_RELEASE: begin
                if (!out_ack) begin
                    state_next = HS_IDLE;
                end
            end
            default: state_next = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // loaded only on pop, so it holds through the handshake
    always_ff @(posedge clk) begin
        if (pop) begin
            out_data <= result;
        end
    end

endmodule

// ==== norm_top.sv ====
`timescale 1ns/1ps

module norm_top import norm_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_req,
    input  norm_in_t  in_data,
    output logic      in_ack,
    output logic      out_req,
    output norm_out_t out_data,
    input  logic      out_ack
);

    logic     push;
    norm_in_t push_data;
    logic     full;
    norm_in_t head;
    logic     empty;
    logic     pop;

    norm_ingress i_ingress (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .full     (full),
        .push     (push),
        .push_data(push_data)
    );

    norm_fifo i_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_data(push_data),
        .pop      (pop),
        .head     (head),
        .full     (full),
        .empty    (empty)
    );

    norm_shifter i_shifter (
        .clk     (clk),
        .rst     (rst),
        .head    (head),
        .empty   (empty),
        .pop     (pop),
        .out_req (out_req),
        .out_data(out_data),
        .out_ack (out_ack)
    );

endmodule

// ==== norm_properties.sv ====
`timescale 1ns/1ps

module norm_properties import norm_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      in_req,
    input logic      in_ack,
    input logic      out_req,
    input logic      out_ack,
    input norm_out_t out_data,
    input logic      push,
    input logic      pop
);

    int fail_count = 0;
    int occupancy;

    // entries held in the FIFO, tracked from push and pop alone
    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push) - int'(pop);
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else begin
            $error("in_ack rose without a pending in_req");
            fail_count++;
        end

    // sender keeps asking until the sink answers
    req_held: assert property (@(posedge clk) disable iff (rst)
        out_req && !out_ack |=> out_req)
        else begin
            $error("out_req dropped before out_ack rose");
            fail_count++;
        end

    data_stable: assert property (@(posedge clk) disable iff (rst)
        out_req && $past(out_req) |-> $stable(out_data))
        else begin
            $error("out_data changed while out_req was high");
            fail_count++;
        end

    no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> occupancy < FIFO_DEPTH)
        else begin
            $error("FIFO pushed while full");
            fail_count++;
        end

    no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> occupancy > 0)
        else begin
            $error("FIFO popped while empty");
            fail_count++;
        end

endmodule

// ==== norm_checker.sv ====
`timescale 1ns/1ps

module norm_checker import norm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  norm_in_t   in_data,
    input  logic       in_ack,
    input  logic       out_req,
    input  norm_out_t  out_data,
    input  logic [2:0] test_id,
    input  logic       drain,
    output int         errors,
    output int         results,
    output logic       drained
);

    norm_in_t   sent_q [$];
    logic [2:0] test_q [$];
    logic       ack_q;
    logic       req_q;

    // leading one by linear scan, then shift and exponent adjust
    function automatic norm_out_t ref_norm(norm_in_t op);
        norm_out_t r;
        int        idx;
        int        shift;
        idx = -1;
        for (int i = 0; i < MANT_W; i++) begin
            if (op.mant[i]) begin
                idx = i;
            end
        end
        r.tag   = op.tag;
        r.zero  = 1'b0;
        r.uflow = 1'b0;
        if (idx < 0) begin
            r.mant = '0;
            r.exp  = '0;
            r.zero = 1'b1;
        end else begin
            shift  = MANT_W - 1 - idx;
            r.mant = op.mant << shift;
            if (int'(op.exp) > shift) begin
                r.exp = op.exp - EXP_W'(shift);
            end else begin
                r.exp   = '0;
                r.uflow = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic string test_name(logic [2:0] id);
        string s;
        case (id)
            3'd0:    s = "zero_operand";
            3'd1:    s = "single_bit";
            3'd2:    s = "random_mantissa";
            3'd3:    s = "underflow";
            default: s = "back_pressure";
        endcase
        return s;
    endfunction

    task automatic compare_field(string tname, logic [TAG_W-1:0] tag, string field,
                                 logic [MANT_W-1:0] want, logic [MANT_W-1:0] got);
        if (want !== got) begin
            $display("** Error %s tag %0d %s: expected %0h, actual %0h",
                     tname, tag, field, want, got);
            errors++;
        end
    endtask

    task automatic check_result();
        norm_in_t   op;
        norm_out_t  want;
        string      tname;
        results++;
        if (sent_q.size() == 0) begin
            $display("extra result with tag %0d and no acked operand behind it", out_data.tag);
            errors++;
        end else begin
            op    = sent_q.pop_front();
            tname = test_name(test_q.pop_front());
            want  = ref_norm(op);
            compare_field(tname, op.tag, "tag", MANT_W'(want.tag), MANT_W'(out_data.tag));
            compare_field(tname, op.tag, "exp", MANT_W'(want.exp), MANT_W'(out_data.exp));
            compare_field(tname, op.tag, "mant", want.mant, out_data.mant);
            compare_field(tname, op.tag, "zero", MANT_W'(want.zero), MANT_W'(out_data.zero));
            compare_field(tname, op.tag, "uflow", MANT_W'(want.uflow), MANT_W'(out_data.uflow));
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ack_q   = 1'b0;
            req_q   = 1'b0;
            errors  = 0;
            results = 0;
            drained = 1'b0;
            sent_q.delete();
            test_q.delete();
        end else begin
            // operand counts as accepted once ack rises
            if (in_ack && !ack_q) begin
                sent_q.push_back(in_data);
                test_q.push_back(test_id);
            end
            if (out_req && !req_q) begin
                check_result();
            end
            ack_q = in_ack;
            req_q = out_req;
            if (drain && !drained) begin
                if (sent_q.size() != 0) begin
                    $display("missing results: %0d acked operands never came out",
                             sent_q.size());
                    errors++;
                end
                drained = 1'b1;
            end
        end
    end

endmodule

// ==== tb_norm_top.sv ====
`timescale 1ns/1ps

module tb_norm_top import norm_pkg::*; ();

    localparam logic [31:0] SEED = 32'hf779c6ab;
    localparam int RESET_CYCLES    = 16;
    localparam int N_ZERO          = 4;
    localparam int N_BITS          = 128;
    localparam int N_RAND          = 60;
    localparam int N_UFLOW         = 20;
    localparam int N_BP            = 24;
    localparam int TOTAL           = N_ZERO + N_BITS + N_RAND + N_UFLOW + N_BP;
    localparam int CYCLES_PER_ITEM = 40;
    localparam int LIMIT           = TOTAL * CYCLES_PER_ITEM + RESET_CYCLES;

    logic             clk;
    logic             rst;
    logic             in_req;
    norm_in_t         in_data;
    logic             in_ack;
    logic             out_req;
    norm_out_t        out_data;
    logic             out_ack;
    logic [2:0]       test_id;
    logic             drain;
    logic             drained;
    int               errors;
    int               results;
    int               total_errors;
    int               cycles;
    int               lz;
    logic             slow_sink;
    logic [TAG_W-1:0] next_tag;
    logic [EXP_W-1:0] exponent;
    logic [EXP_W-1:0] zero_exps [N_ZERO] = '{16'h0000, 16'h0001, 16'h8000, 16'hffff};

    norm_top i_norm_top (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .in_data (in_data),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_data(out_data),
        .out_ack (out_ack)
    );

    norm_checker i_checker (
        .clk     (clk),
        .rst     (rst),
        .in_data (in_data),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_data(out_data),
        .test_id (test_id),
        .drain   (drain),
        .errors  (errors),
        .results (results),
        .drained (drained)
    );

    bind norm_top norm_properties i_props (
        .clk(clk), .rst(rst), .in_req(in_req), .in_ack(in_ack),
        .out_req(out_req), .out_ack(out_ack), .out_data(out_data),
        .push(push), .pop(pop)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // forced leading one with random bits below it
    function automatic logic [MANT_W-1:0] random_mant(int lead_zeros);
        logic [MANT_W-1:0] m;
        m = {$urandom, $urandom, $urandom, $urandom};
        if (lead_zeros >= MANT_W) begin
            return '0;
        end
        m = m >> lead_zeros;
        m[MANT_W-1-lead_zeros] = 1'b1;
        return m;
    endfunction

    task automatic send_operand(logic [2:0] id, logic [EXP_W-1:0] exp_in,
                                logic [MANT_W-1:0] mant_in);
        test_id = id;
        in_data = '{tag: next_tag, exp: exp_in, mant: mant_in};
        in_req  = 1'b1;
        next_tag++;
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
    endtask

    // sink acks after a random delay that grows under back-pressure
    initial begin : sink
        int delay;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack) begin
                delay = slow_sink ? 12 + int'($urandom % 8) : int'($urandom % 9);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b1;
                while (out_req) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d results seen", cycles, results, TOTAL);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        in_req    = 1'b0;
        in_data   = '0;
        test_id   = 3'd0;
        drain     = 1'b0;
        slow_sink = 1'b0;
        next_tag  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < N_ZERO; i++) begin
            send_operand(3'd0, zero_exps[i], '0);
        end
        for (int pos = 0; pos < N_BITS; pos++) begin
            send_operand(3'd1, 16'h4000, MANT_W'(1) << pos);
        end
        for (int i = 0; i < N_RAND; i++) begin
            lz = int'($urandom % 129);
            send_operand(3'd2, 16'($urandom), random_mant(lz));
        end
        // even items sit exactly on the shift amount
        for (int i = 0; i < N_UFLOW; i++) begin
            lz       = int'($urandom % 128);
            exponent = (i % 2 == 0) ? 16'(lz) : 16'($urandom % (lz + 1));
            send_operand(3'd3, exponent, random_mant(lz));
        end
        slow_sink = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            send_operand(3'd4, 16'($urandom), random_mant(int'($urandom % 128)));
        end
        while (results < TOTAL) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        #1;
        drain = 1'b1;
        wait (drained);
        total_errors = errors + i_norm_top.i_props.fail_count;
        $display("closing: %0d results, %0d checker errors, %0d assertion failures",
                 results, errors, i_norm_top.i_props.fail_count);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
norm_pkg.sv
lzc_64.sv
lzc_128.sv
norm_ingress.sv
norm_fifo.sv
norm_shifter.sv
norm_top.sv
norm_properties.sv
norm_checker.sv
tb_norm_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_norm_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
